//--- design/ahb_matrix_defines.svh
// Bus matrix widths, master and slave counts, slave address map
`ifndef AHB_MATRIX_DEFINES_SVH
`define AHB_MATRIX_DEFINES_SVH

// Bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Matrix size
`define AHB_MASTERS 3
`define AHB_SLAVES 2

//////////////////////////////////////////////////////////////////////
// Slave map
//////////////////////////////////////////////////////////////////////

// Base of each SRAM window
`define AHB_SLV0_BASE 32'h0000_0000
`define AHB_SLV1_BASE 32'h0001_0000

// SRAM depth in 32-bit words, window is 4x this in bytes
`define AHB_SLV_WORDS 256

`endif

//--- design/ahb_matrix_pkg.sv
// Vector typedefs, AHB transfer and response encodings, router state enum
`default_nettype none

`include "ahb_matrix_defines.svh"

package ahb_matrix_pkg;

  // Bus vectors
  typedef logic [`AHB_ADDR_W-1:0] haddr_t;
  typedef logic [`AHB_DATA_W-1:0] hdata_t;
  typedef logic [1:0]             htrans_t;
  typedef logic [2:0]             hsize_t;
  typedef logic [2:0]             hburst_t;
  typedef logic [3:0]             hprot_t;

  // Arbitration level, higher wins
  typedef logic [2:0] prio_t;

  // One bit per master / per slave
  typedef logic [`AHB_MASTERS-1:0]         mst_vec_t;
  typedef logic [`AHB_SLAVES-1:0]          slv_vec_t;
  typedef logic [$clog2(`AHB_MASTERS)-1:0] mst_idx_t;

  // HTRANS encodings
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  // HRESP encodings
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // Response router states
  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_WAIT,
    RESP_ERR1,
    RESP_ERR2
  } resp_state_t;

endpackage

`default_nettype wire

//--- design/ahb_addr_decoder.sv
// Per-master address decoder with decode-error flag and lock-based switch permission
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defines.svh"

module ahb_addr_decoder (
  input  wire                           HCLK,
  input  wire                           HRESETn,
  input  wire                           hsel,
  input  wire ahb_matrix_pkg::haddr_t   haddr,
  input  wire ahb_matrix_pkg::htrans_t  htrans,
  input  wire                           hmastlock,
  output ahb_matrix_pkg::slv_vec_t      slave_req,
  output logic                          dec_err,
  output logic                          can_switch
);

  // Window size in bytes, same for every SRAM
  localparam int SLV_BYTES = `AHB_SLV_WORDS * 4;

  localparam ahb_matrix_pkg::haddr_t SLV_BASE [`AHB_SLAVES] = '{`AHB_SLV0_BASE, `AHB_SLV1_BASE};

  logic                     active;
  logic                     lock_q;
  ahb_matrix_pkg::slv_vec_t hit;

  // IDLE and BUSY carry no address phase
  assign active = hsel &&
                  (htrans != ahb_matrix_pkg::HTRANS_IDLE) &&
                  (htrans != ahb_matrix_pkg::HTRANS_BUSY);

  // Range compare against each window
  always_comb begin
    for (int s = 0; s < `AHB_SLAVES; s++) begin
      hit[s] = (haddr >= SLV_BASE[s]) &&
               (haddr < SLV_BASE[s] + ahb_matrix_pkg::haddr_t'(SLV_BYTES));
    end
  end

  assign slave_req = active ? hit : '0;

  // Active transfer outside every window
  assign dec_err = active && !(|hit);

  // Lock seen last cycle covers the data phase of the last locked transfer
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= hmastlock;
    end
  end

  // Slave stays with this master while locked
  assign can_switch = !(hmastlock || lock_q);

endmodule

`default_nettype wire

//--- design/ahb_slave_port_arbiter.sv
// Per-slave priority and round-robin arbiter with address and write data multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defines.svh"

module ahb_slave_port_arbiter (
  input  wire                                              HCLK,
  input  wire                                              HRESETn,
  // Master side, one entry per master
  input  wire ahb_matrix_pkg::mst_vec_t                    mst_sel,
  input  wire ahb_matrix_pkg::prio_t   [`AHB_MASTERS-1:0]  mst_priority,
  input  wire ahb_matrix_pkg::haddr_t  [`AHB_MASTERS-1:0]  mst_haddr,
  input  wire ahb_matrix_pkg::hdata_t  [`AHB_MASTERS-1:0]  mst_hwdata,
  input  wire ahb_matrix_pkg::mst_vec_t                    mst_hwrite,
  input  wire ahb_matrix_pkg::hsize_t  [`AHB_MASTERS-1:0]  mst_hsize,
  input  wire ahb_matrix_pkg::hburst_t [`AHB_MASTERS-1:0]  mst_hburst,
  input  wire ahb_matrix_pkg::hprot_t  [`AHB_MASTERS-1:0]  mst_hprot,
  input  wire ahb_matrix_pkg::htrans_t [`AHB_MASTERS-1:0]  mst_htrans,
  input  wire ahb_matrix_pkg::mst_vec_t                    mst_hmastlock,
  input  wire ahb_matrix_pkg::mst_vec_t                    can_switch,
  // Slave side
  output logic                                             slv_hsel,
  output ahb_matrix_pkg::haddr_t                           slv_haddr,
  output ahb_matrix_pkg::hdata_t                           slv_hwdata,
  output logic                                             slv_hwrite,
  output ahb_matrix_pkg::hsize_t                           slv_hsize,
  output ahb_matrix_pkg::hburst_t                          slv_hburst,
  output ahb_matrix_pkg::hprot_t                           slv_hprot,
  output ahb_matrix_pkg::htrans_t                          slv_htrans,
  output logic                                             slv_hmastlock,
  input  wire                                              slv_hready,
  output ahb_matrix_pkg::mst_vec_t                         granted_master
);

  // One remembered grant per priority level
  localparam int LEVELS = 2 ** $bits(ahb_matrix_pkg::prio_t);

  ahb_matrix_pkg::prio_t    req_level;
  ahb_matrix_pkg::mst_vec_t level_masters;
  ahb_matrix_pkg::mst_vec_t pending_master;
  ahb_matrix_pkg::mst_vec_t last_grant [LEVELS];
  ahb_matrix_pkg::mst_idx_t grant_idx;
  ahb_matrix_pkg::mst_idx_t grant_idx_dly;
  logic                     switch_ok;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic ahb_matrix_pkg::mst_idx_t to_idx(input ahb_matrix_pkg::mst_vec_t oh);
    to_idx = '0;
    for (int n = 0; n < `AHB_MASTERS; n++) begin
      if (oh[n]) to_idx = ahb_matrix_pkg::mst_idx_t'(n);
    end
  endfunction

  // Round-robin pick, starting after the level's last grant
  function automatic ahb_matrix_pkg::mst_vec_t next_master(
    input ahb_matrix_pkg::mst_vec_t pending,
    input ahb_matrix_pkg::mst_vec_t last,
    input ahb_matrix_pkg::mst_vec_t current
  );
    int cand;
    next_master = current;
    // Walk backwards so the nearest requester wins
    for (int n = `AHB_MASTERS; n >= 1; n--) begin
      cand = (int'(to_idx(last)) + n) % `AHB_MASTERS;
      if (pending[cand]) next_master = ahb_matrix_pkg::mst_vec_t'(1) << cand;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  // Highest level among requesters, and who sits at it
  always_comb begin
    req_level = '0;
    for (int n = 0; n < `AHB_MASTERS; n++) begin
      if (mst_sel[n] && mst_priority[n] > req_level) req_level = mst_priority[n];
    end
    for (int n = 0; n < `AHB_MASTERS; n++) begin
      level_masters[n] = mst_sel[n] && (mst_priority[n] == req_level);
    end
  end

  assign pending_master = next_master(level_masters, last_grant[req_level], granted_master);

  // Locked owner holds the slave
  assign switch_ok = can_switch[grant_idx];

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      granted_master <= ahb_matrix_pkg::mst_vec_t'(1);
      for (int l = 0; l < LEVELS; l++) last_grant[l] <= ahb_matrix_pkg::mst_vec_t'(1);
    end else if (slv_hready && switch_ok) begin
      granted_master        <= pending_master;
      last_grant[req_level] <= pending_master;
    end
  end

  // Address index follows the grant, write data index lags one phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      grant_idx     <= '0;
      grant_idx_dly <= '0;
    end else if (slv_hready) begin
      grant_idx     <= to_idx(switch_ok ? pending_master : granted_master);
      grant_idx_dly <= grant_idx;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slave-side multiplexer
  //////////////////////////////////////////////////////////////////////

  assign slv_hsel      = mst_sel[grant_idx];
  assign slv_haddr     = mst_haddr[grant_idx];
  assign slv_hwrite    = mst_hwrite[grant_idx];
  assign slv_hsize     = mst_hsize[grant_idx];
  assign slv_hburst    = mst_hburst[grant_idx];
  assign slv_hprot     = mst_hprot[grant_idx];
  assign slv_htrans    = mst_htrans[grant_idx];
  assign slv_hmastlock = mst_hmastlock[grant_idx];
  // Data phase belongs to the previously accepted master
  assign slv_hwdata    = mst_hwdata[grant_idx_dly];

endmodule

`default_nettype wire

//--- design/ahb_resp_router.sv
// Per-master response router with data-phase tracking and local ERROR response
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defines.svh"

module ahb_resp_router (
  input  wire                                            HCLK,
  input  wire                                            HRESETn,
  input  wire ahb_matrix_pkg::slv_vec_t                  slave_req,
  input  wire                                            dec_err,
  input  wire ahb_matrix_pkg::htrans_t                   htrans,
  input  wire ahb_matrix_pkg::slv_vec_t                  granted,
  input  wire ahb_matrix_pkg::hdata_t [`AHB_SLAVES-1:0]  slv_hrdata,
  input  wire ahb_matrix_pkg::slv_vec_t                  slv_hready,
  input  wire ahb_matrix_pkg::slv_vec_t                  slv_hresp,
  output ahb_matrix_pkg::hdata_t                         hrdata,
  output logic                                           hready,
  output logic                                           hresp
);

  ahb_matrix_pkg::resp_state_t state_q;
  ahb_matrix_pkg::slv_vec_t    owner_q;
  logic                        active;
  logic                        blocked;

  assign active = (htrans == ahb_matrix_pkg::HTRANS_NONSEQ) ||
                  (htrans == ahb_matrix_pkg::HTRANS_SEQ);

  // Requested slave not ours yet, or still busy with someone else
  assign blocked = |(slave_req & ~(granted & slv_hready));

  // Master-side HREADY and HRESP
  always_comb begin
    case (state_q)
      ahb_matrix_pkg::RESP_IDLE: hready = !blocked;
      ahb_matrix_pkg::RESP_WAIT: hready = |(owner_q & slv_hready);
      ahb_matrix_pkg::RESP_ERR1: hready = 1'b0;
      default:                   hready = 1'b1;
    endcase
    case (state_q)
      ahb_matrix_pkg::RESP_WAIT: hresp = |(owner_q & slv_hresp);
      ahb_matrix_pkg::RESP_ERR1,
      ahb_matrix_pkg::RESP_ERR2: hresp = ahb_matrix_pkg::HRESP_ERROR;
      default:                   hresp = ahb_matrix_pkg::HRESP_OKAY;
    endcase
  end

  // Read data from the data-phase owner
  always_comb begin
    hrdata = '0;
    for (int s = 0; s < `AHB_SLAVES; s++) begin
      if (owner_q[s]) hrdata = slv_hrdata[s];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data-phase FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= ahb_matrix_pkg::RESP_IDLE;
      owner_q <= '0;
    end else if (state_q == ahb_matrix_pkg::RESP_ERR1) begin
      // Second ERROR cycle with HREADY high
      state_q <= ahb_matrix_pkg::RESP_ERR2;
    end else if (hready) begin
      // Phase boundary, take the next address phase if any
      if (active && dec_err) begin
        state_q <= ahb_matrix_pkg::RESP_ERR1;
        owner_q <= '0;
      end else if (active && (|slave_req)) begin
        state_q <= ahb_matrix_pkg::RESP_WAIT;
        owner_q <= slave_req;
      end else begin
        state_q <= ahb_matrix_pkg::RESP_IDLE;
        owner_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/ahb_sram_slave.sv
// Word-addressed SRAM slave, zero-wait writes and one wait state on reads
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defines.svh"

module ahb_sram_slave (
  input  wire                           HCLK,
  input  wire                           HRESETn,
  input  wire                           hsel,
  input  wire ahb_matrix_pkg::haddr_t   haddr,
  input  wire                           hwrite,
  input  wire ahb_matrix_pkg::htrans_t  htrans,
  input  wire ahb_matrix_pkg::hdata_t   hwdata,
  input  wire                           hready,
  output ahb_matrix_pkg::hdata_t        hrdata,
  output logic                          hready_out,
  output logic                          hresp
);

  localparam int IDX_W = $clog2(`AHB_SLV_WORDS);

  ahb_matrix_pkg::hdata_t mem [`AHB_SLV_WORDS];
  ahb_matrix_pkg::hdata_t rdata_q;
  logic [IDX_W-1:0]       word_q;
  logic                   accept;
  logic                   wr_pend;
  logic                   rd_wait;

  // Address phase taken at an edge with HREADY high
  assign accept = hsel && hready &&
                  ((htrans == ahb_matrix_pkg::HTRANS_NONSEQ) ||
                   (htrans == ahb_matrix_pkg::HTRANS_SEQ));

  // Data-phase control
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_pend <= 1'b0;
      rd_wait <= 1'b0;
    end else begin
      wr_pend <= accept && hwrite;
      rd_wait <= accept && !hwrite;
    end
  end

  // Storage and captured word index
  always_ff @(posedge HCLK) begin
    if (accept) begin
      word_q <= haddr[IDX_W+1:2];
    end
    // Write data arrives one cycle after the address
    if (wr_pend) begin
      mem[word_q] <= hwdata;
    end
    // Read in the wait cycle, shown in the next one
    if (rd_wait) begin
      rdata_q <= mem[word_q];
    end
  end

  assign hready_out = !rd_wait;
  assign hrdata     = rdata_q;
  assign hresp      = ahb_matrix_pkg::HRESP_OKAY;

endmodule

`default_nettype wire

//--- design/ahb_matrix_top.sv
// Bus matrix top with decoders, slave-port arbiters, response routers and SRAM slaves
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defines.svh"

module ahb_matrix_top (
  input  wire                                              HCLK,
  input  wire                                              HRESETn,
  input  wire ahb_matrix_pkg::mst_vec_t                    m_hsel,
  input  wire ahb_matrix_pkg::prio_t   [`AHB_MASTERS-1:0]  m_priority,
  input  wire ahb_matrix_pkg::haddr_t  [`AHB_MASTERS-1:0]  m_haddr,
  input  wire ahb_matrix_pkg::hdata_t  [`AHB_MASTERS-1:0]  m_hwdata,
  input  wire ahb_matrix_pkg::mst_vec_t                    m_hwrite,
  input  wire ahb_matrix_pkg::hsize_t  [`AHB_MASTERS-1:0]  m_hsize,
  input  wire ahb_matrix_pkg::hburst_t [`AHB_MASTERS-1:0]  m_hburst,
  input  wire ahb_matrix_pkg::hprot_t  [`AHB_MASTERS-1:0]  m_hprot,
  input  wire ahb_matrix_pkg::htrans_t [`AHB_MASTERS-1:0]  m_htrans,
  input  wire ahb_matrix_pkg::mst_vec_t                    m_hmastlock,
  output ahb_matrix_pkg::hdata_t  [`AHB_MASTERS-1:0]       m_hrdata,
  output ahb_matrix_pkg::mst_vec_t                         m_hready,
  output ahb_matrix_pkg::mst_vec_t                         m_hresp
);

  // Decoder outputs, indexed by master
  ahb_matrix_pkg::slv_vec_t slave_req [`AHB_MASTERS];
  ahb_matrix_pkg::mst_vec_t dec_err;
  ahb_matrix_pkg::mst_vec_t can_switch;

  // Same request and grant bits, seen from either side
  ahb_matrix_pkg::mst_vec_t slv_sel   [`AHB_SLAVES];
  ahb_matrix_pkg::mst_vec_t slv_grant [`AHB_SLAVES];
  ahb_matrix_pkg::slv_vec_t mst_grant [`AHB_MASTERS];

  // Slave-side buses
  ahb_matrix_pkg::slv_vec_t                     s_hsel;
  ahb_matrix_pkg::haddr_t  [`AHB_SLAVES-1:0]    s_haddr;
  ahb_matrix_pkg::hdata_t  [`AHB_SLAVES-1:0]    s_hwdata;
  ahb_matrix_pkg::slv_vec_t                     s_hwrite;
  ahb_matrix_pkg::htrans_t [`AHB_SLAVES-1:0]    s_htrans;
  ahb_matrix_pkg::hdata_t  [`AHB_SLAVES-1:0]    s_hrdata;
  ahb_matrix_pkg::slv_vec_t                     s_hready;
  ahb_matrix_pkg::slv_vec_t                     s_hresp;

  genvar m, s;

  // Transpose master/slave matrices
  for (m = 0; m < `AHB_MASTERS; m++) begin : g_xpose_m
    for (s = 0; s < `AHB_SLAVES; s++) begin : g_xpose_s
      assign slv_sel[s][m]   = slave_req[m][s];
      assign mst_grant[m][s] = slv_grant[s][m];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Master layers
  //////////////////////////////////////////////////////////////////////

  for (m = 0; m < `AHB_MASTERS; m++) begin : g_mst
    ahb_addr_decoder i_dec (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .hsel       (m_hsel[m]),
      .haddr      (m_haddr[m]),
      .htrans     (m_htrans[m]),
      .hmastlock  (m_hmastlock[m]),
      .slave_req  (slave_req[m]),
      .dec_err    (dec_err[m]),
      .can_switch (can_switch[m])
    );

    ahb_resp_router i_router (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .slave_req  (slave_req[m]),
      .dec_err    (dec_err[m]),
      .htrans     (m_htrans[m]),
      .granted    (mst_grant[m]),
      .slv_hrdata (s_hrdata),
      .slv_hready (s_hready),
      .slv_hresp  (s_hresp),
      .hrdata     (m_hrdata[m]),
      .hready     (m_hready[m]),
      .hresp      (m_hresp[m])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Slave ports
  //////////////////////////////////////////////////////////////////////

  for (s = 0; s < `AHB_SLAVES; s++) begin : g_slv
    // SRAM takes word accesses only, size/burst/prot/lock stop here
    ahb_slave_port_arbiter i_arb (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .mst_sel        (slv_sel[s]),
      .mst_priority   (m_priority),
      .mst_haddr      (m_haddr),
      .mst_hwdata     (m_hwdata),
      .mst_hwrite     (m_hwrite),
      .mst_hsize      (m_hsize),
      .mst_hburst     (m_hburst),
      .mst_hprot      (m_hprot),
      .mst_htrans     (m_htrans),
      .mst_hmastlock  (m_hmastlock),
      .can_switch     (can_switch),
      .slv_hsel       (s_hsel[s]),
      .slv_haddr      (s_haddr[s]),
      .slv_hwdata     (s_hwdata[s]),
      .slv_hwrite     (s_hwrite[s]),
      .slv_hsize      (),
      .slv_hburst     (),
      .slv_hprot      (),
      .slv_htrans     (s_htrans[s]),
      .slv_hmastlock  (),
      .slv_hready     (s_hready[s]),
      .granted_master (slv_grant[s])
    );

    // HREADY loops back from the slave's own output
    ahb_sram_slave i_sram (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .hsel       (s_hsel[s]),
      .haddr      (s_haddr[s]),
      .hwrite     (s_hwrite[s]),
      .htrans     (s_htrans[s]),
      .hwdata     (s_hwdata[s]),
      .hready     (s_hready[s]),
      .hrdata     (s_hrdata[s]),
      .hready_out (s_hready[s]),
      .hresp      (s_hresp[s])
    );
  end

endmodule

`default_nettype wire

//--- bench/ahb_matrix_model.svh
// Reference SRAM memory, address decode, expected responses and completion order bookkeeping
`ifndef AHB_MATRIX_MODEL_SVH
`define AHB_MATRIX_MODEL_SVH

// Mirror of each SRAM, updated as writes complete
ahb_matrix_pkg::hdata_t model_mem [`AHB_SLAVES][`AHB_SLV_WORDS];

// Master index of every finished data phase, in finish order
int done_log [$];

// Owning slave of an address, -1 outside both windows
function automatic int slave_of(input ahb_matrix_pkg::haddr_t addr);
  ahb_matrix_pkg::haddr_t span;
  span = ahb_matrix_pkg::haddr_t'(`AHB_SLV_WORDS * 4);
  slave_of = -1;
  // Unsigned offset covers both window bounds
  if (ahb_matrix_pkg::haddr_t'(addr - `AHB_SLV0_BASE) < span) slave_of = 0;
  if (ahb_matrix_pkg::haddr_t'(addr - `AHB_SLV1_BASE) < span) slave_of = 1;
endfunction

// Word inside the window
function automatic int word_of(input ahb_matrix_pkg::haddr_t addr);
  word_of = int'((addr >> 2) % `AHB_SLV_WORDS);
endfunction

// Unmapped transfers get ERROR, mapped ones OKAY
function automatic logic expected_resp(input ahb_matrix_pkg::haddr_t addr);
  if (slave_of(addr) < 0) expected_resp = ahb_matrix_pkg::HRESP_ERROR;
  else expected_resp = ahb_matrix_pkg::HRESP_OKAY;
endfunction

function automatic ahb_matrix_pkg::hdata_t expected_word(input ahb_matrix_pkg::haddr_t addr);
  expected_word = model_mem[slave_of(addr)][word_of(addr)];
endfunction

// Unmapped writes leave every memory alone
function automatic void store_word(input ahb_matrix_pkg::haddr_t addr,
                                   input ahb_matrix_pkg::hdata_t data);
  if (slave_of(addr) >= 0) model_mem[slave_of(addr)][word_of(addr)] = data;
endfunction

function automatic void note_done(input int m);
  done_log.push_back(m);
endfunction

// Log position of the nth finished transfer of master m, -1 if missing
function automatic int done_pos(input int m, input int nth);
  int seen;
  seen = 0;
  done_pos = -1;
  for (int i = 0; i < done_log.size(); i++) begin
    if (done_log[i] == m) begin
      if (seen == nth && done_pos < 0) done_pos = i;
      seen++;
    end
  end
endfunction

// Each group of AHB_MASTERS finishes holds every master once
function automatic bit rounds_fair(input int rounds);
  ahb_matrix_pkg::mst_vec_t seen;
  rounds_fair = (done_log.size() == rounds * `AHB_MASTERS);
  for (int r = 0; r < rounds && rounds_fair; r++) begin
    seen = '0;
    for (int k = 0; k < `AHB_MASTERS; k++) seen[done_log[r * `AHB_MASTERS + k]] = 1'b1;
    if (seen != '1) rounds_fair = 1'b0;
  end
endfunction

`endif

//--- bench/ahb_matrix_tb.sv
// Bus matrix testbench with clock, reset, random and directed master traffic, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defines.svh"

module ahb_matrix_tb;

  localparam int CLK_PERIOD = 100;
  localparam int POOL       = 8;   // words per slave touched by the tests
  localparam int RAND_TXN   = 40;  // random transfers per master
  localparam int RR_ROUNDS  = 4;
  // Preload, random, park plus priority pair, round-robin, lock
  localparam int TOTAL_TXN  = 2 * POOL + 3 * RAND_TXN + 3 + 3 * RR_ROUNDS + 3;

  logic                                       HCLK;
  logic                                       HRESETn;
  ahb_matrix_pkg::mst_vec_t                   m_hsel;
  ahb_matrix_pkg::prio_t   [`AHB_MASTERS-1:0] m_priority;
  ahb_matrix_pkg::haddr_t  [`AHB_MASTERS-1:0] m_haddr;
  ahb_matrix_pkg::hdata_t  [`AHB_MASTERS-1:0] m_hwdata;
  ahb_matrix_pkg::mst_vec_t                   m_hwrite;
  ahb_matrix_pkg::hsize_t  [`AHB_MASTERS-1:0] m_hsize;
  ahb_matrix_pkg::hburst_t [`AHB_MASTERS-1:0] m_hburst;
  ahb_matrix_pkg::hprot_t  [`AHB_MASTERS-1:0] m_hprot;
  ahb_matrix_pkg::htrans_t [`AHB_MASTERS-1:0] m_htrans;
  ahb_matrix_pkg::mst_vec_t                   m_hmastlock;
  ahb_matrix_pkg::hdata_t  [`AHB_MASTERS-1:0] m_hrdata;
  ahb_matrix_pkg::mst_vec_t                   m_hready;
  ahb_matrix_pkg::mst_vec_t                   m_hresp;

  `include "ahb_matrix_model.svh"

  ahb_matrix_top i_dut (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .m_hsel      (m_hsel),
    .m_priority  (m_priority),
    .m_haddr     (m_haddr),
    .m_hwdata    (m_hwdata),
    .m_hwrite    (m_hwrite),
    .m_hsize     (m_hsize),
    .m_hburst    (m_hburst),
    .m_hprot     (m_hprot),
    .m_htrans    (m_htrans),
    .m_hmastlock (m_hmastlock),
    .m_hrdata    (m_hrdata),
    .m_hready    (m_hready),
    .m_hresp     (m_hresp)
  );

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input ahb_matrix_pkg::hdata_t exp,
                            input ahb_matrix_pkg::hdata_t act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error: %s expected hresp %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Master side
  //////////////////////////////////////////////////////////////////////

  // Region 0/1 is a slave window, anything else lands past both
  function automatic ahb_matrix_pkg::haddr_t pool_addr(input int region, input int word);
    ahb_matrix_pkg::haddr_t base;
    case (region)
      0:       base = `AHB_SLV0_BASE;
      1:       base = `AHB_SLV1_BASE;
      default: base = 32'h0002_0000;
    endcase
    pool_addr = base + ahb_matrix_pkg::haddr_t'(word * 4);
  endfunction

  // Single NONSEQ transfer, called at 1 ns after a rising edge, returns the same way
  task automatic issue_transfer(input int m, input ahb_matrix_pkg::haddr_t addr,
                                input logic write, input ahb_matrix_pkg::prio_t prio,
                                input logic lock_addr, input logic lock_data,
                                input string name);
    ahb_matrix_pkg::hdata_t wdata;
    logic                   exp_resp;
    wdata    = ahb_matrix_pkg::hdata_t'($urandom);
    exp_resp = expected_resp(addr);
    m_hsel[m]      = 1'b1;
    m_haddr[m]     = addr;
    m_hwrite[m]    = write;
    m_priority[m]  = prio;
    m_hmastlock[m] = lock_addr;
    m_htrans[m]    = ahb_matrix_pkg::HTRANS_NONSEQ;
    // Address held while the matrix pushes back, sampled mid-cycle
    @(negedge HCLK);
    while (!m_hready[m]) @(negedge HCLK);
    @(posedge HCLK);
    #1;
    // Non-pipelined master, IDLE during the data phase
    m_hsel[m]      = 1'b0;
    m_htrans[m]    = ahb_matrix_pkg::HTRANS_IDLE;
    m_hmastlock[m] = lock_data;
    m_hwdata[m]    = wdata;
    // No OKAY cycle allowed inside an ERROR phase, and the reverse
    @(negedge HCLK);
    check_resp(name, exp_resp, m_hresp[m]);
    while (!m_hready[m]) begin
      @(negedge HCLK);
      check_resp(name, exp_resp, m_hresp[m]);
    end
    if (!write && exp_resp == ahb_matrix_pkg::HRESP_OKAY) begin
      check_data(name, expected_word(addr), m_hrdata[m]);
    end
    if (write) store_word(addr, wdata);
    note_done(m);
    @(posedge HCLK);
    #1;
  endtask

  // Mixed reads and writes, one in ten unmapped, random gaps
  task automatic random_traffic(input int m);
    int region;
    int gap;
    for (int n = 0; n < RAND_TXN; n++) begin
      region = ($urandom_range(9, 0) == 0) ? 2 : int'($urandom_range(1, 0));
      issue_transfer(m, pool_addr(region, int'($urandom_range(POOL - 1, 0))),
                     1'($urandom_range(1, 0)), ahb_matrix_pkg::prio_t'($urandom_range(7, 0)),
                     1'b0, 1'b0, "random");
      gap = int'($urandom_range(2, 0));
      repeat (gap) begin
        @(posedge HCLK);
        #1;
      end
    end
  endtask

  // Equal priority, back to back on slave 0
  task automatic fair_traffic(input int m);
    for (int n = 0; n < RR_ROUNDS; n++) begin
      issue_transfer(m, pool_addr(0, m), 1'b1, 3'd3, 1'b0, 1'b0, "round_robin");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h5f2e7ad6));
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    m_hsel      = '0;
    m_priority  = '0;
    m_haddr     = '0;
    m_hwdata    = '0;
    m_hwrite    = '0;
    m_hsize     = {`AHB_MASTERS{3'b010}};
    m_hburst    = '0;
    m_hprot     = {`AHB_MASTERS{4'b0011}};
    m_htrans    = '0;
    m_hmastlock = '0;
    repeat (10) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    // Idle bus after reset
    @(negedge HCLK);
    for (int m = 0; m < `AHB_MASTERS; m++) begin
      check_resp("reset", ahb_matrix_pkg::HRESP_OKAY, m_hresp[m]);
    end
    if (m_hready !== '1) begin
      $display("reset: a master sees hready low before any transfer");
      abort_run();
    end
    @(posedge HCLK);
    #1;
    // Every pool word gets a known value
    for (int s = 0; s < `AHB_SLAVES; s++) begin
      for (int w = 0; w < POOL; w++) begin
        issue_transfer(0, pool_addr(s, w), 1'b1, 3'd1, 1'b0, 1'b0, "preload");
      end
    end
    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
    join
    // Park slave 1 on master 1, then race masters 0 and 2
    // Round-robin from master 1 alone would pick master 2
    issue_transfer(1, pool_addr(1, 0), 1'b1, 3'd0, 1'b0, 1'b0, "priority");
    done_log.delete();
    fork
      issue_transfer(0, pool_addr(1, 1), 1'b0, 3'd5, 1'b0, 1'b0, "priority");
      issue_transfer(2, pool_addr(1, 2), 1'b0, 3'd2, 1'b0, 1'b0, "priority");
    join
    if (done_pos(0, 0) > done_pos(2, 0)) begin
      $display("priority: master 2 finished before higher-priority master 0");
      abort_run();
    end
    done_log.delete();
    fork
      fair_traffic(0);
      fair_traffic(1);
      fair_traffic(2);
    join
    if (!rounds_fair(RR_ROUNDS)) begin
      $display("round_robin: a master finished twice before another finished once");
      abort_run();
    end
    // Locked write then read, competitor joins two cycles late
    done_log.delete();
    fork
      begin
        issue_transfer(0, pool_addr(0, 3), 1'b1, 3'd1, 1'b1, 1'b1, "lock");
        issue_transfer(0, pool_addr(0, 3), 1'b0, 3'd1, 1'b1, 1'b0, "lock");
      end
      begin
        repeat (2) @(posedge HCLK);
        #1;
        issue_transfer(1, pool_addr(0, 4), 1'b1, 3'd7, 1'b0, 1'b0, "lock");
      end
    join
    if (done_pos(1, 0) < done_pos(0, 1)) begin
      $display("lock: competing master got in between the locked transfers");
      abort_run();
    end
    $display("Result: PASSED");
    $finish;
  end

  // Generous bound, forty cycles per transfer
  initial begin
    #(TOTAL_TXN * 40 * CLK_PERIOD);
    $display("timeout: the transfers did not finish in the allowed time");
    abort_run();
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
+incdir+bench
design/ahb_matrix_pkg.sv
design/ahb_addr_decoder.sv
design/ahb_slave_port_arbiter.sv
design/ahb_resp_router.sv
design/ahb_sram_slave.sv
design/ahb_matrix_top.sv
bench/ahb_matrix_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the bus matrix testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module ahb_matrix_tb \
  --Mdir obj_dir \
  -f flist.f

./obj_dir/Vahb_matrix_tb 2>&1 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
